// File: vlog.f
common/uart_pkg.sv
common/muldiv_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
muldiv/mul_engine.sv
muldiv/div_engine.sv
hw/operand_collector.sv
hw/reply_sender.sv
hw/muldiv_top.sv
testbench/muldiv_props.sv
testbench/tb_muldiv.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build with verilator from vlog.f, run, then judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_muldiv -f vlog.f -o sim_muldiv > build.log 2>&1 \
   || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_muldiv +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
! grep -q "TEST FAILED" sim.log && grep -q "TEST PASSED" sim.log && exit 0 || exit 1

// File: testbench/tb_muldiv.sv
`timescale 1ns/1ps

module tb_muldiv import uart_pkg::*, muldiv_pkg::*; ();

   localparam int commands       = 13;   // fixed, ten random, two zero cases
   localparam int timeout_cycles = commands * 7000 + 8;

   logic i_clk;
   logic i_nrst;
   logic i_uart_rx;
   logic o_uart_tx;
   int   errors = 0;
   int   cycles = 0;
   int   seed;

   muldiv_top dut_i (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_uart_rx(i_uart_rx), .o_uart_tx(o_uart_tx)
   );

   bind muldiv_top muldiv_props props_i (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_req(req), .i_mul_ack(mul_ack),
      .i_div_ack(div_ack), .i_tx_busy(tx_busy), .i_sender_busy(sender_busy),
      .i_uart_tx(o_uart_tx)
   );

   always #4 i_clk = ~i_clk;   // 8 ns period

   always @(posedge i_clk) begin
      cycles <= cycles + 1;
      if (cycles >= timeout_cycles) begin
         $display("timeout after %0d cycles, a reply never completed", cycles);
         $display("TEST FAILED");
         $finish;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // serial host side

   // lsb first with each bit driven just after the clock edge
   task automatic send_byte(input operand_t data);
      logic [frame_bits-1:0] frame;
      frame = {1'b1, data, 1'b0};
      for (int i = 0; i < frame_bits; i++) begin
         @(posedge i_clk);
         #1 i_uart_rx = frame[i];
         repeat (bit_clocks - 1) @(posedge i_clk);
      end
   endtask

   task automatic receive_byte(output operand_t data);
      @(negedge i_clk);
      while (o_uart_tx === 1'b1) @(negedge i_clk);   // hunt for start bit
      repeat (half_bit) @(negedge i_clk);
      for (int i = 0; i < 8; i++) begin
         repeat (bit_clocks) @(negedge i_clk);
         data[i] = o_uart_tx;
      end
      repeat (bit_clocks) @(negedge i_clk);
      stop_bit: assert (o_uart_tx === 1'b1) else begin
         errors++;
         $display("[FAIL] %0t o_uart_tx stop bit: got %b expected 1", $time, o_uart_tx);
      end
   endtask

   function automatic string byte_name(input int idx);
      case (idx)
         0:       return "product_lo";
         1:       return "product_hi";
         2:       return "quotient";
         default: return "remainder";
      endcase
   endfunction

   //////////////////////////////////////////////////////////////////////
   // one command, operands out and four reply bytes back

   task automatic run_command(input operand_t a, input operand_t b);
      operand_t got  [reply_bytes];
      operand_t want [reply_bytes];
      product_t prod;
      prod    = product_t'(a) * product_t'(b);
      want[0] = prod[7:0];
      want[1] = prod[15:8];
      want[2] = (b == '0) ? 8'hFF : a / b;   // divide by zero gives all ones
      want[3] = (b == '0) ? a : a % b;
      fork
         begin
            send_byte(a);
            send_byte(b);
         end
         begin
            for (int k = 0; k < reply_bytes; k++) receive_byte(got[k]);
         end
      join
      for (int k = 0; k < reply_bytes; k++) begin
         reply_byte: assert (got[k] === want[k]) else begin
            errors++;
            $display("[FAIL] %0t %s (a=%0d b=%0d): got %02h expected %02h",
                     $time, byte_name(k), a, b, got[k], want[k]);
         end
      end
   endtask

   initial begin
      operand_t a;
      operand_t b;
      i_clk     = 1'b0;
      i_nrst    = 1'b0;
      i_uart_rx = 1'b1;   // idle line
      seed      = 75022;
      repeat (8) @(posedge i_clk);
      #1 i_nrst = 1'b1;
      run_command(8'd200, 8'd7);
      repeat (10) begin
         a = operand_t'($random(seed));
         b = operand_t'($random(seed));
         run_command(a, b);
      end
      run_command(8'd123, 8'd0);
      run_command(8'd0, 8'd45);
      $display("errors: %0d in testbench checks, %0d in assertions",
               errors, dut_i.props_i.prop_errors);
      if (errors == 0 && dut_i.props_i.prop_errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// File: testbench/muldiv_props.sv
`timescale 1ns/1ps

module muldiv_props (
   input logic i_clk,
   input logic i_nrst,
   input logic i_req,
   input logic i_mul_ack,
   input logic i_div_ack,
   input logic i_tx_busy,
   input logic i_sender_busy,
   input logic i_uart_tx
);

   int prop_errors = 0;   // failed property count

   //////////////////////////////////////////////////////////////////////
   // four-phase handshake between collector and engines

   req_held: assert property (@(posedge i_clk) disable iff (!i_nrst)
      (i_req && !(i_mul_ack && i_div_ack)) |=> i_req)
   else begin
      prop_errors++;
      $error("req fell before both acks were high");
   end

   ack_rise: assert property (@(posedge i_clk) disable iff (!i_nrst)
      ($rose(i_mul_ack) || $rose(i_div_ack)) |-> i_req)
   else begin
      prop_errors++;
      $error("an ack rose while req was low");
   end

   // ack may only drop once req has been seen low
   ack_fall: assert property (@(posedge i_clk) disable iff (!i_nrst)
      ($fell(i_mul_ack) || $fell(i_div_ack)) |-> !$past(i_req))
   else begin
      prop_errors++;
      $error("an ack fell while req was still high");
   end

   //////////////////////////////////////////////////////////////////////
   // serial output

   // no reply in progress means an idle transmitter and a high line
   line_idle: assert property (@(posedge i_clk) disable iff (!i_nrst)
      !i_sender_busy |-> (!i_tx_busy && i_uart_tx))
   else begin
      prop_errors++;
      $error("tx line active while no reply is in progress");
   end

endmodule

// File: hw/muldiv_top.sv
`timescale 1ns/1ps

module muldiv_top import muldiv_pkg::*; (
   input  logic i_clk,
   input  logic i_nrst,
   input  logic i_uart_rx,
   output logic o_uart_tx
);

   operand_t rx_byte;
   logic     rx_valid;
   logic     req;
   operand_t op_a;
   operand_t op_b;
   logic     mul_ack;
   logic     div_ack;
   logic     results_ready;
   product_t product;
   operand_t quotient;
   operand_t remainder;
   logic     sender_busy;
   operand_t tx_byte;
   logic     tx_start;
   logic     tx_busy;

   //////////////////////////////////////////////////////////////////////
   // receive side and command handshake

   uart_rx uart_rx_i (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_rx(i_uart_rx),
      .o_byte(rx_byte), .o_byte_valid(rx_valid)
   );

   operand_collector collector_i (
      .i_clk(i_clk), .i_nrst(i_nrst),
      .i_byte(rx_byte), .i_byte_valid(rx_valid),
      .i_mul_ack(mul_ack), .i_div_ack(div_ack), .i_sender_busy(sender_busy),
      .o_req(req), .o_a(op_a), .o_b(op_b), .o_results_ready(results_ready)
   );

   // both engines run on every command
   mul_engine mul_i (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_req(req), .i_a(op_a), .i_b(op_b),
      .o_ack(mul_ack), .o_product(product)
   );

   div_engine div_i (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_req(req), .i_a(op_a), .i_b(op_b),
      .o_ack(div_ack), .o_quotient(quotient), .o_remainder(remainder)
   );

   //////////////////////////////////////////////////////////////////////
   // reply side

   reply_sender sender_i (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_results_ready(results_ready),
      .i_product(product), .i_quotient(quotient), .i_remainder(remainder),
      .i_tx_busy(tx_busy), .o_tx_byte(tx_byte), .o_tx_start(tx_start),
      .o_busy(sender_busy)
   );

   uart_tx uart_tx_i (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_start(tx_start), .i_byte(tx_byte),
      .o_tx(o_uart_tx), .o_busy(tx_busy)
   );

endmodule

// File: hw/reply_sender.sv
`timescale 1ns/1ps

module reply_sender import muldiv_pkg::*; (
   input  logic     i_clk,
   input  logic     i_nrst,
   input  logic     i_results_ready,
   input  product_t i_product,
   input  operand_t i_quotient,
   input  operand_t i_remainder,
   input  logic     i_tx_busy,
   output operand_t o_tx_byte,
   output logic     o_tx_start,
   output logic     o_busy
);

   typedef enum logic [1:0] {
      snd_idle,
      snd_issue,   // waiting for the transmitter to be free
      snd_wait     // byte on the line
   } snd_state_t;

   typedef logic [$clog2(reply_bytes)-1:0] index_t;

   snd_state_t state;
   index_t     idx;
   operand_t   reply [reply_bytes];
   logic       last;

   assign last = (idx == index_t'(reply_bytes - 1));

   //////////////////////////////////////////////////////////////////////
   // byte sequencing

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= snd_idle;
         idx   <= '0;
      end else begin
         case (state)
            snd_idle: if (i_results_ready) begin
               idx   <= '0;
               state <= snd_issue;
            end
            snd_issue: if (!i_tx_busy) state <= snd_wait;
            snd_wait: if (!i_tx_busy) begin   // stop bit finished
               if (last) begin
                  state <= snd_idle;
               end else begin
                  idx   <= idx + 1'b1;
                  state <= snd_issue;
               end
            end
            default: state <= snd_idle;
         endcase
      end
   end

   // reply order on the wire
   always_ff @(posedge i_clk) begin
      if (state == snd_idle && i_results_ready) begin
         reply[0] <= i_product[operand_bits-1:0];
         reply[1] <= i_product[2*operand_bits-1:operand_bits];
         reply[2] <= i_quotient;
         reply[3] <= i_remainder;
      end
   end

   assign o_tx_byte  = reply[idx];
   assign o_tx_start = (state == snd_issue) & ~i_tx_busy;
   assign o_busy     = (state != snd_idle);

endmodule

// File: hw/operand_collector.sv
`timescale 1ns/1ps

module operand_collector import muldiv_pkg::*; (
   input  logic     i_clk,
   input  logic     i_nrst,
   input  operand_t i_byte,
   input  logic     i_byte_valid,
   input  logic     i_mul_ack,
   input  logic     i_div_ack,
   input  logic     i_sender_busy,
   output logic     o_req,
   output operand_t o_a,
   output operand_t o_b,
   output logic     o_results_ready
);

   typedef enum logic [1:0] {
      col_a,        // waiting for operand a
      col_b,        // waiting for operand b
      col_req,      // req high, waiting for both acks
      col_release   // req low, waiting for both acks to fall
   } col_state_t;

   col_state_t state;
   logic       take;
   logic       both_ack;

   assign take     = i_byte_valid & ~i_sender_busy;  // reply in progress drops bytes
   assign both_ack = i_mul_ack & i_div_ack;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= col_a;
      end else begin
         case (state)
            col_a:       if (take) state <= col_b;
            col_b:       if (take) state <= col_req;
            col_req:     if (both_ack) state <= col_release;
            col_release: if (!i_mul_ack && !i_div_ack) state <= col_a;
            default:     state <= col_a;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (state == col_a && take) o_a <= i_byte;
      if (state == col_b && take) o_b <= i_byte;
   end

   assign o_req           = (state == col_req);
   assign o_results_ready = o_req & both_ack;   // only once, state moves on

endmodule

// File: muldiv/div_engine.sv
`timescale 1ns/1ps

module div_engine import muldiv_pkg::*; (
   input  logic     i_clk,
   input  logic     i_nrst,
   input  logic     i_req,
   input  operand_t i_a,
   input  operand_t i_b,
   output logic     o_ack,
   output operand_t o_quotient,
   output operand_t o_remainder
);

   typedef logic [$clog2(div_steps + 1)-1:0] step_t;

   logic                  busy;
   logic                  start;
   step_t                 steps;
   operand_t              rem;
   logic [operand_bits:0] partial;  // remainder shifted left, next dividend bit in
   logic [operand_bits:0] diff;
   logic                  fits;

   assign start   = i_req & ~busy & ~o_ack;
   assign partial = {rem, o_quotient[operand_bits-1]};
   assign diff    = partial - {1'b0, i_b};
   assign fits    = (partial >= {1'b0, i_b});  // b = 0 always fits, quotient FF

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         busy  <= 1'b0;
         o_ack <= 1'b0;
      end else if (start) begin
         busy <= 1'b1;
      end else if (busy && steps == '0) begin
         busy  <= 1'b0;
         o_ack <= 1'b1;
      end else if (o_ack && !i_req) begin
         o_ack <= 1'b0;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // restoring shift-subtract, dividend shifts out as quotient shifts in

   always_ff @(posedge i_clk) begin
      if (start) begin
         steps      <= step_t'(div_steps);
         rem        <= '0;
         o_quotient <= i_a;
      end else if (busy && steps != '0) begin
         steps      <= steps - 1'b1;
         rem        <= fits ? diff[operand_bits-1:0] : partial[operand_bits-1:0];
         o_quotient <= {o_quotient[operand_bits-2:0], fits};
      end
   end

   assign o_remainder = rem;

endmodule

// File: muldiv/mul_engine.sv
`timescale 1ns/1ps

module mul_engine import muldiv_pkg::*; (
   input  logic     i_clk,
   input  logic     i_nrst,
   input  logic     i_req,
   input  operand_t i_a,
   input  operand_t i_b,
   output logic     o_ack,
   output product_t o_product
);

   logic     busy;
   logic     start;
   operand_t count;   // copy of a, counts down to zero

   assign start = i_req & ~busy & ~o_ack;

   //////////////////////////////////////////////////////////////////////
   // handshake side

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         busy  <= 1'b0;
         o_ack <= 1'b0;
      end else if (start) begin
         busy <= 1'b1;
      end else if (busy && count == '0) begin
         busy  <= 1'b0;
         o_ack <= 1'b1;                // product now frozen
      end else if (o_ack && !i_req) begin
         o_ack <= 1'b0;
      end
   end

   // repeated addition of b, a times
   always_ff @(posedge i_clk) begin
      if (start) begin
         count     <= i_a;
         o_product <= '0;
      end else if (busy && count != '0) begin
         o_product <= o_product + product_t'(i_b);
         count     <= count - 1'b1;
      end
   end

endmodule

// File: uart/uart_tx.sv
`timescale 1ns/1ps

module uart_tx import uart_pkg::*, muldiv_pkg::*; (
   input  logic     i_clk,
   input  logic     i_nrst,
   input  logic     i_start,
   input  operand_t i_byte,
   output logic     o_tx,
   output logic     o_busy
);

   typedef enum logic [1:0] {
      tx_idle,
      tx_start,
      tx_send
   } tx_state_t;

   typedef logic [$clog2(frame_bits)-1:0] frame_cnt_t;

   tx_state_t  state;
   bit_count_t count;
   frame_cnt_t bits_done;
   operand_t   shreg;
   logic       bit_end;
   logic       last_bit;

   assign bit_end  = (state != tx_idle) & (count == bit_count_t'(bit_clocks - 1));
   assign last_bit = (bits_done == frame_cnt_t'(frame_bits - 1));

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state     <= tx_idle;
         count     <= '0;
         bits_done <= '0;
      end else begin
         count <= (state == tx_idle || bit_end) ? '0 : count + 1'b1;
         case (state)
            tx_idle: begin
               bits_done <= '0;
               if (i_start) state <= tx_start;
            end
            tx_start: if (bit_end) begin
               bits_done <= bits_done + 1'b1;
               state     <= tx_send;
            end
            tx_send: if (bit_end) begin
               if (last_bit) state <= tx_idle;  // stop bit done
               else          bits_done <= bits_done + 1'b1;
            end
            default: state <= tx_idle;
         endcase
      end
   end

   // ones shift in behind the data, the last of them is the stop bit
   always_ff @(posedge i_clk) begin
      if (state == tx_idle && i_start)    shreg <= i_byte;
      else if (state == tx_send && bit_end) shreg <= {1'b1, shreg[7:1]};
   end

   assign o_tx   = (state == tx_idle)  ? 1'b1 :
                   (state == tx_start) ? 1'b0 :
                                         shreg[0];
   assign o_busy = (state != tx_idle);

endmodule

// File: uart/uart_rx.sv
`timescale 1ns/1ps

module uart_rx import uart_pkg::*, muldiv_pkg::*; (
   input  logic     i_clk,
   input  logic     i_nrst,
   input  logic     i_rx,
   output operand_t o_byte,
   output logic     o_byte_valid
);

   typedef enum logic [1:0] {
      rx_idle,
      rx_start,
      rx_data,
      rx_stop
   } rx_state_t;

   logic [1:0] rx_sync;
   rx_state_t  state;
   bit_count_t count;
   operand_t   shreg;
   logic       rx_line;
   logic       bit_end;
   logic       half_end;

   assign rx_line  = rx_sync[1];
   assign bit_end  = (count == bit_count_t'(bit_clocks - 1));
   assign half_end = (count == bit_count_t'(half_bit - 1));

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) rx_sync <= 2'b11;    // line idles high
      else         rx_sync <= {rx_sync[0], i_rx};
   end

   //////////////////////////////////////////////////////////////////////
   // frame state machine

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= rx_idle;
         count <= '0;
      end else begin
         count <= count + 1'b1;
         case (state)
            rx_idle: begin
               count <= '0;
               if (!rx_line) state <= rx_start;
            end
            rx_start: if (half_end) begin
               count <= '0;
               state <= rx_line ? rx_idle : rx_data;  // glitch, not a start bit
            end
            rx_data: if (bit_end) begin
               count <= '0;
               if (shreg[0]) state <= rx_stop;  // marker about to drop out
            end
            rx_stop: if (bit_end) state <= rx_idle;
            default: state <= rx_idle;
         endcase
      end
   end

   // lsb first, marker travels ahead of the data
   always_ff @(posedge i_clk) begin
      if (state == rx_idle)              shreg <= rx_marker;
      else if (state == rx_data && bit_end) shreg <= {rx_line, shreg[7:1]};
   end

   assign o_byte       = shreg;
   assign o_byte_valid = (state == rx_stop) & bit_end & rx_line;  // mid stop bit

endmodule

// File: common/muldiv_pkg.sv
package muldiv_pkg;

   //////////////////////////////////////////////////////////////////////
   // arithmetic widths

   localparam int operand_bits = 8;
   localparam int div_steps    = 8;  // one quotient bit per step
   localparam int reply_bytes  = 4;  // prod lo, prod hi, quot, rem

   // one operand or one result byte
   typedef logic [operand_bits-1:0] operand_t;

   // full product of two operands
   typedef logic [2*operand_bits-1:0] product_t;

endpackage

// File: common/uart_pkg.sv
package uart_pkg;

   //////////////////////////////////////////////////////////////////////
   // serial bit timing

   localparam int bit_clocks = 104;            // clocks per serial bit
   localparam int half_bit   = bit_clocks / 2; // start bit centre
   localparam int frame_bits = 10;             // start, 8 data, stop

   // rx shift register seed, reaches bit 0 after seven shifts
   localparam logic [7:0] rx_marker = 8'h80;

   // sized to hold one full bit period
   typedef logic [$clog2(bit_clocks)-1:0] bit_count_t;

endpackage
